//--- common/fpa_config.svh
/*
	word widths and field sizes of the FPU mantissa datapath
*/

`ifndef FPA_CONFIG_SVH
`define FPA_CONFIG_SVH

// 40-bit mantissa of the machine format
`define FPA_WIDTH 40

// W and ZP bus word
`define FPA_WORD 16

// third slice of T, placed in the upper half of a bus word
`define FPA_LOW_BITS 8

// shift count field of the W word
`define FPA_CNT_BITS 6

`endif

//--- common/fpa_pkg.sv
/*
	command, micro-op, slice, flag and mantissa types of the FPU datapath
*/

`default_nettype none

`include "fpa_config.svh"

package fpa_pkg;

	typedef enum logic [2:0] {
		cmd_nop = 3'd0,
		cmd_ldw = 3'd1,
		cmd_t2c = 3'd2,
		cmd_t2m = 3'd3,
		cmd_add = 3'd4,
		cmd_sub = 3'd5,
		cmd_clr = 3'd6,
		cmd_shf = 3'd7
	} fpa_cmd_e;

	// T slices on the W and ZP buses, last code is the flag word
	typedef enum logic [1:0] {
		slice_hi    = 2'd0,
		slice_mid   = 2'd1,
		slice_lo    = 2'd2,
		slice_flags = 2'd3
	} fpa_slice_e;

	typedef struct packed {
		logic                 t_load;
		fpa_slice_e           slice;
		logic [`FPA_WORD-1:0] w;
		logic                 t_shl;
		logic                 t_shr;
		logic                 t_sum;
		logic                 sub;
		logic                 t_clr;
		logic                 t2c;
		logic                 t2m;
	} fpa_uop_t;

	typedef struct packed {
		logic [`FPA_WORD-1:0]     hi;
		logic [`FPA_WORD-1:0]     mid;
		logic [`FPA_LOW_BITS-1:0] lo;
	} fpa_words_t;

	// raw for the adder, words for bus loads and readout
	typedef union packed {
		logic [`FPA_WIDTH-1:0] raw;
		fpa_words_t            words;
	} fpa_mant_u;

	typedef struct packed {
		logic z;
		logic s;
		logic c;
		logic v;
	} fpa_flags_t;

endpackage

`default_nettype wire

//--- files.f
+incdir+common
common/fpa_pkg.sv
hw/fpa/fpa_adder.sv
hw/fpa/fpa.sv
hw/fp_sequencer.sv
hw/fp_readout.sv
hw/fpu_arith.sv
test/fpa_checker.sv
test/tb_fpu_arith.sv

//--- hw/fp_readout.sv
/*
	ZP bus slice multiplexer, zero and sign detection, flag register
*/

`default_nettype none

`include "fpa_config.svh"

module fp_readout
	import fpa_pkg::*;
(
	input  wire                  strob_fp_,
	input  wire                  _0_t_,
	input  fpa_mant_u            t_q,
	input  wire                  carry,
	input  wire                  ovf,
	input  wire                  arith_done,
	input  fpa_slice_e           rd_sel,
	output logic [`FPA_WORD-1:0] zp,
	output fpa_flags_t           flags
);

	// flags follow the T written by the last add or subtract
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			flags <= '0;
		end else if (arith_done) begin
			flags.z <= ~|t_q.raw;
			flags.s <= t_q.raw[`FPA_WIDTH-1];
			flags.c <= carry;
			flags.v <= ovf;
		end
	end

	always_comb begin
		case (rd_sel)
			slice_hi:  zp = t_q.words.hi;
			slice_mid: zp = t_q.words.mid;
			// short slice left-aligned
			slice_lo:  zp = {t_q.words.lo, {(`FPA_WORD - `FPA_LOW_BITS){1'b0}}};
			default:   zp = {flags, {(`FPA_WORD - 4){1'b0}}};
		endcase
	end

endmodule

`default_nettype wire

//--- hw/fp_sequencer.sv
/*
	command decoder and shift counter, one registered micro-op per clock
*/

`default_nettype none

`include "fpa_config.svh"

module fp_sequencer
	import fpa_pkg::*;
(
	input  wire                  strob_fp_,
	input  wire                  _0_t_,
	input  wire                  cmd_stb,
	input  fpa_cmd_e             cmd,
	input  wire [`FPA_WORD-1:0]  w,
	output fpa_uop_t             uop,
	output logic                 busy
);

	fpa_uop_t                  uop_d;
	logic [`FPA_CNT_BITS-1:0]  cnt;
	logic                      dir;
	logic                      accept;
	logic                      shf_start;

	assign accept    = cmd_stb && !busy;
	assign shf_start = accept && (cmd == cmd_shf);

	always_comb begin
		uop_d = '0;
		if (busy) begin
			// remaining shift steps, dir 1 is right
			if (cnt != '0) begin
				uop_d.t_shl = !dir;
				uop_d.t_shr = dir;
			end
		end else if (cmd_stb) begin
			case (cmd)
				cmd_ldw: begin
					// no T slice behind the flag code
					if (fpa_slice_e'(w[1:0]) != slice_flags) begin
						uop_d.t_load = 1'b1;
						uop_d.slice  = fpa_slice_e'(w[1:0]);
						uop_d.w      = w;
					end
				end
				cmd_t2c: uop_d.t2c = 1'b1;
				cmd_t2m: uop_d.t2m = 1'b1;
				cmd_add: uop_d.t_sum = 1'b1;
				cmd_sub: begin
					uop_d.t_sum = 1'b1;
					uop_d.sub   = 1'b1;
				end
				cmd_clr: uop_d.t_clr = 1'b1;
				cmd_shf: begin
					uop_d.t_shl = !w[15];
					uop_d.t_shr = w[15];
				end
				default: uop_d = '0;
			endcase
		end
	end

	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			uop  <= '0;
			busy <= 1'b0;
			cnt  <= '0;
			dir  <= 1'b0;
		end else begin
			uop <= uop_d;
			if (shf_start) begin
				// first step goes out now, count 0 means one step
				busy <= 1'b1;
				dir  <= w[15];
				cnt  <= (w[`FPA_CNT_BITS-1:0] == '0) ? '0 : w[`FPA_CNT_BITS-1:0] - 1'b1;
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	a_busy_from_shf : assert property (
		@(posedge strob_fp_) disable iff (!_0_t_)
		$rose(busy) |-> $past(cmd_stb && cmd == cmd_shf)
	);

	a_one_t_op : assert property (
		@(posedge strob_fp_) disable iff (!_0_t_)
		$onehot0({uop.t_load, uop.t_shl, uop.t_shr, uop.t_sum, uop.t_clr})
	);

endmodule

`default_nettype wire

//--- hw/fpa/fpa.sv
/*
	T, C and M mantissa registers with load, shift, copy and add/subtract paths
*/

`default_nettype none

`include "fpa_config.svh"

module fpa
	import fpa_pkg::*;
(
	input  wire        strob_fp_,
	input  wire        _0_t_,
	input  fpa_uop_t   uop,
	output fpa_mant_u  t_q,
	output logic       carry,
	output logic       ovf,
	output logic       arith_done
);

	fpa_mant_u             t;
	logic [`FPA_WIDTH-1:0] c;
	logic [`FPA_WIDTH-1:0] m;

	logic [`FPA_WIDTH-1:0] sum;
	logic                  add_c;
	logic                  add_v;

	// T plus or minus C, always present on sum
	fpa_adder fpa_adder_inst (
		.a     (t.raw),
		.b     (c),
		.sub   (uop.sub),
		.sum   (sum),
		.carry (add_c),
		.ovf   (add_v)
	);

	// T register
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			t.raw <= '0;
		end else if (uop.t_clr) begin
			t.raw <= '0;
		end else if (uop.t_load) begin
			case (uop.slice)
				slice_hi: begin
					t.words.hi <= uop.w;
				end
				slice_mid: begin
					t.words.mid <= uop.w;
				end
				slice_lo: begin
					// upper byte of W lands in the short slice
					t.words.lo <= uop.w[`FPA_WORD-1 -: `FPA_LOW_BITS];
				end
				default: begin
					t.raw <= t.raw;
				end
			endcase
		end else if (uop.t_shl) begin
			// left shift, in-bit from the top of M
			t.raw <= {t.raw[`FPA_WIDTH-2:0], m[`FPA_WIDTH-1]};
		end else if (uop.t_shr) begin
			// right shift, in-bit from the bottom of M
			t.raw <= {m[0], t.raw[`FPA_WIDTH-1:1]};
		end else if (uop.t_sum) begin
			t.raw <= sum;
		end
	end

	// C operand register
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			c <= '0;
		end else if (uop.t2c) begin
			c <= t.raw;
		end
	end

	// M auxiliary register, source of shift in-bits
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			m <= '0;
		end else if (uop.t2m) begin
			m <= t.raw;
		end
	end

	// adder status captured with the sum
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			carry      <= 1'b0;
			ovf        <= 1'b0;
			arith_done <= 1'b0;
		end else begin
			arith_done <= uop.t_sum;
			if (uop.t_sum) begin
				carry <= add_c;
				ovf   <= add_v;
			end
		end
	end

	assign t_q = t;

	// the sequencer drops slice loads aimed at the flag word
	a_no_flag_load : assert property (
		@(posedge strob_fp_) disable iff (!_0_t_)
		uop.t_load |-> (uop.slice != slice_flags)
	);

endmodule

`default_nettype wire

//--- hw/fpa/fpa_adder.sv
/*
	40-bit add/subtract, 4-bit groups with carry lookahead between them
*/

`default_nettype none

`include "fpa_config.svh"

module fpa_adder (
	input  wire [`FPA_WIDTH-1:0] a,
	input  wire [`FPA_WIDTH-1:0] b,
	input  wire                  sub,
	output logic [`FPA_WIDTH-1:0] sum,
	output logic                  carry,
	output logic                  ovf
);

	localparam int GROUPS = `FPA_WIDTH / 4;

	logic [`FPA_WIDTH-1:0] bx;
	logic [`FPA_WIDTH-1:0] g;
	logic [`FPA_WIDTH-1:0] p;
	logic [`FPA_WIDTH-1:0] cb;
	logic [GROUPS-1:0]     grp_g;
	logic [GROUPS-1:0]     grp_p;
	logic [GROUPS:0]       gc;

	// subtract as a + ~b + 1
	assign bx = sub ? ~b : b;
	assign g  = a & bx;
	assign p  = a ^ bx;

	genvar k;
	generate
		for (k = 0; k < GROUPS; k++) begin : grp
			assign grp_g[k] = g[4*k+3] | (p[4*k+3] & g[4*k+2]) |
				(p[4*k+3] & p[4*k+2] & g[4*k+1]) |
				(p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
			assign grp_p[k] = &p[4*k+3:4*k];
			// bit carries inside the group
			assign cb[4*k]   = gc[k];
			assign cb[4*k+1] = g[4*k] | (p[4*k] & gc[k]);
			assign cb[4*k+2] = g[4*k+1] | (p[4*k+1] & cb[4*k+1]);
			assign cb[4*k+3] = g[4*k+2] | (p[4*k+2] & cb[4*k+2]);
		end
	endgenerate

	// group carries as sum of products over G/P
	always_comb begin
		logic term;
		for (int i = 0; i <= GROUPS; i++) begin
			gc[i] = 1'b0;
			for (int j = -1; j < i; j++) begin
				term = (j < 0) ? sub : grp_g[j];
				for (int q = j + 1; q < i; q++) begin
					term = term & grp_p[q];
				end
				gc[i] = gc[i] | term;
			end
		end
	end

	assign sum   = p ^ cb;
	assign carry = gc[GROUPS];
	assign ovf   = (a[`FPA_WIDTH-1] == bx[`FPA_WIDTH-1]) &
		(sum[`FPA_WIDTH-1] != a[`FPA_WIDTH-1]);

endmodule

`default_nettype wire

//--- hw/fpu_arith.sv
/*
	FPU mantissa arithmetic top: sequencer, datapath and readout
*/

`default_nettype none

`include "fpa_config.svh"

module fpu_arith
	import fpa_pkg::*;
(
	input  wire                  strob_fp_,
	input  wire                  _0_t_,
	input  wire                  cmd_stb,
	input  fpa_cmd_e             cmd,
	input  wire [`FPA_WORD-1:0]  w,
	input  fpa_slice_e           rd_sel,
	output logic                 busy,
	output logic [`FPA_WORD-1:0] zp,
	output fpa_flags_t           flags
);

	fpa_uop_t  uop;
	fpa_mant_u t_q;
	logic      carry;
	logic      ovf;
	logic      arith_done;

	fp_sequencer fp_sequencer_inst (
		.strob_fp_ (strob_fp_),
		._0_t_     (_0_t_),
		.cmd_stb   (cmd_stb),
		.cmd       (cmd),
		.w         (w),
		.uop       (uop),
		.busy      (busy)
	);

	fpa fpa_inst (
		.strob_fp_  (strob_fp_),
		._0_t_      (_0_t_),
		.uop        (uop),
		.t_q        (t_q),
		.carry      (carry),
		.ovf        (ovf),
		.arith_done (arith_done)
	);

	fp_readout fp_readout_inst (
		.strob_fp_  (strob_fp_),
		._0_t_      (_0_t_),
		.t_q        (t_q),
		.carry      (carry),
		.ovf        (ovf),
		.arith_done (arith_done),
		.rd_sel     (rd_sel),
		.zp         (zp),
		.flags      (flags)
	);

endmodule

`default_nettype wire

//--- test/fpa_checker.sv
/*
	reference model of T, C, M, flags and busy for the FPU mantissa datapath,
	compares busy every clock, each ZP read and the flags port after each test
*/

`default_nettype none

`include "fpa_config.svh"

module fpa_checker
	import fpa_pkg::*;
(
	input  wire                     strob_fp_,
	input  wire                     _0_t_,
	input  wire                     cmd_stb,
	input  fpa_cmd_e                cmd,
	input  wire [`FPA_WORD-1:0]     w,
	input  fpa_slice_e              rd_sel,
	input  wire                     busy,
	input  wire [`FPA_WORD-1:0]     zp,
	input  fpa_flags_t              flags,
	input  wire                     rd_chk,
	input  wire                     use_exp,
	input  wire [4*`FPA_WORD-1:0]   exp_words,
	input  wire                     test_done,
	output int                      tests,
	output int                      errors
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [`FPA_WIDTH-1:0] t_m;
	logic [`FPA_WIDTH-1:0] c_m;
	logic [`FPA_WIDTH-1:0] m_m;
	fpa_flags_t            flg_m;
	int                    busy_left;
	int                    test_err;

	// compare first, then advance the model with the inputs of this edge
	always @(posedge strob_fp_ or negedge _0_t_) begin
		logic [`FPA_WIDTH-1:0] bx;
		logic [`FPA_WIDTH:0]   full;
		logic [`FPA_WORD-1:0]  want;
		logic [`FPA_WORD-1:0]  file_want;
		int                    k;
		if (!_0_t_) begin
			t_m       = '0;
			c_m       = '0;
			m_m       = '0;
			flg_m     = '0;
			busy_left = 0;
			test_err  = 0;
			tests     = 0;
			errors    = 0;
		end else begin
			if (busy !== (busy_left != 0)) begin
				$display("ERR %0t: busy is %b, model expects %b", $time, busy, busy_left != 0);
				errors++;
				test_err++;
			end
			if (rd_chk) begin
				case (rd_sel)
					slice_hi:  want = t_m[39:24];
					slice_mid: want = t_m[23:8];
					slice_lo:  want = {t_m[7:0], 8'h00};
					default:   want = {flg_m, 12'h000};
				endcase
				file_want = exp_words[(3 - int'(rd_sel)) * 16 +: 16];
				if (zp !== want) begin
					$display("ERR %0t: zp slice %0d is %h, model expects %h",
						$time, rd_sel, zp, want);
					errors++;
					test_err++;
				end
				if (use_exp && (zp !== file_want)) begin
					$display("ERR %0t: zp slice %0d is %h, test file expects %h",
						$time, rd_sel, zp, file_want);
					errors++;
					test_err++;
				end
			end
			if (test_done) begin
				// flags port itself, besides the flag word on zp
				if (flags !== flg_m) begin
					$display("ERR %0t: flags are %b, model expects %b",
						$time, flags, flg_m);
					errors++;
					test_err++;
				end
				tests++;
				if (test_err == 0) begin
					$display("test %0d ok", tests);
				end else begin
					$display("test %0d: %0d mismatches", tests, test_err);
				end
				test_err = 0;
			end
			if (busy_left != 0) begin
				// strobes during a shift are dropped
				busy_left = busy_left - 1;
			end else if (cmd_stb) begin
				case (cmd)
					cmd_ldw: begin
						case (w[1:0])
							2'd0: t_m[39:24] = w;
							2'd1: t_m[23:8] = w;
							2'd2: t_m[7:0] = w[15:8];
							default: ;
						endcase
					end
					cmd_t2c: c_m = t_m;
					cmd_t2m: m_m = t_m;
					cmd_clr: t_m = '0;
					cmd_add, cmd_sub: begin
						bx = (cmd == cmd_sub) ? ~c_m : c_m;
						full = {1'b0, t_m} + {1'b0, bx} + (cmd == cmd_sub);
						flg_m.c = full[40];
						flg_m.v = (t_m[39] == bx[39]) && (full[39] != t_m[39]);
						t_m = full[39:0];
						flg_m.z = (t_m == '0);
						flg_m.s = t_m[39];
					end
					cmd_shf: begin
						k = (w[5:0] == 6'd0) ? 1 : int'(w[5:0]);
						busy_left = k;
						repeat (k) begin
							t_m = w[15] ? {m_m[0], t_m[39:1]} : {t_m[38:0], m_m[39]};
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- test/fpa_tests.txt
# cmd w rnd gap wait chk exp_hi exp_mid exp_lo exp_flags, all hex
# cmd 0 nop 1 ldw 2 t2c 3 t2m 4 add 5 sub 6 clr 7 shf, chk 1 file and model, 2 model only
0 0000 0 2 0 1 0000 0000 0000 0000
1 1234 0 0 0 0 0000 0000 0000 0000
1 5679 0 0 0 0 0000 0000 0000 0000
1 9a02 0 1 0 1 1234 5679 9a00 0000
6 0000 0 0 0 0 0000 0000 0000 0000
1 0102 0 0 0 0 0000 0000 0000 0000
2 0000 0 0 0 0 0000 0000 0000 0000
6 0000 0 0 0 0 0000 0000 0000 0000
5 0000 0 1 0 1 ffff ffff ff00 4000
4 0000 0 1 0 1 0000 0000 0000 a000
1 4000 0 0 0 0 0000 0000 0000 0000
2 0000 0 0 0 0 0000 0000 0000 0000
4 0000 0 1 0 1 8000 0000 0000 5000
6 0000 0 2 0 0 0000 0000 0000 0000
1 4000 0 2 0 0 0000 0000 0000 0000
2 0000 0 2 0 0 0000 0000 0000 0000
4 0000 0 2 0 1 8000 0000 0000 5000
5 0000 0 1 0 1 4000 0000 0000 3000
6 0000 0 0 0 0 0000 0000 0000 0000
1 8000 0 0 0 0 0000 0000 0000 0000
1 0102 0 0 0 0 0000 0000 0000 0000
3 0000 0 0 0 0 0000 0000 0000 0000
6 0000 0 0 0 0 0000 0000 0000 0000
1 0001 0 0 0 0 0000 0000 0000 0000
7 0004 0 0 1 1 0000 0010 0f00 3000
7 8003 0 0 1 1 e000 0002 0100 3000
7 0005 0 0 0 0 0000 0000 0000 0000
1 1230 0 0 1 1 0000 0040 3f00 3000
7 0000 0 0 1 1 0000 0080 7f00 3000
6 0000 0 1 0 1 0000 0000 0000 3000
4 0000 0 1 0 1 4000 0000 0000 0000
7 8001 0 0 1 1 a000 0000 0000 0000
1 0000 1 0 0 0 0000 0000 0000 0000
1 0001 1 0 0 0 0000 0000 0000 0000
1 0002 1 0 0 0 0000 0000 0000 0000
2 0000 0 0 0 0 0000 0000 0000 0000
1 0000 1 0 0 0 0000 0000 0000 0000
4 0000 0 1 0 2 0000 0000 0000 0000
5 0000 0 1 0 2 0000 0000 0000 0000

//--- test/tb_fpu_arith.sv
/*
	testbench top: clock, reset, commands read from the test file, ZP readback
*/

`default_nettype none

`include "fpa_config.svh"

module tb_fpu_arith
	import fpa_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic                   strob_fp_;
	logic                   _0_t_;
	logic                   cmd_stb;
	fpa_cmd_e               cmd;
	logic [`FPA_WORD-1:0]   w;
	fpa_slice_e             rd_sel;
	logic                   busy;
	logic [`FPA_WORD-1:0]   zp;
	fpa_flags_t             flags;
	logic                   rd_chk;
	logic                   use_exp;
	logic [4*`FPA_WORD-1:0] exp_words;
	logic                   test_done;
	int                     tests;
	int                     errors;
	logic                   aborted;
	integer                 seed;

	always #5 strob_fp_ = ~strob_fp_;

	fpu_arith fpu_arith_inst (
		.strob_fp_ (strob_fp_),
		._0_t_     (_0_t_),
		.cmd_stb   (cmd_stb),
		.cmd       (cmd),
		.w         (w),
		.rd_sel    (rd_sel),
		.busy      (busy),
		.zp        (zp),
		.flags     (flags)
	);

	fpa_checker fpa_checker_inst (
		.strob_fp_ (strob_fp_),
		._0_t_     (_0_t_),
		.cmd_stb   (cmd_stb),
		.cmd       (cmd),
		.w         (w),
		.rd_sel    (rd_sel),
		.busy      (busy),
		.zp        (zp),
		.flags     (flags),
		.rd_chk    (rd_chk),
		.use_exp   (use_exp),
		.exp_words (exp_words),
		.test_done (test_done),
		.tests     (tests),
		.errors    (errors)
	);

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge strob_fp_);
			cmd_stb = 1'b0;
		end
	endtask

	task automatic wait_not_busy();
		int cycles;
		cycles = 0;
		while (busy && cycles < 100) begin
			@(negedge strob_fp_);
			cmd_stb = 1'b0;
			cycles++;
		end
		if (busy) begin
			$display("timeout: busy still high after 100 cycles");
			aborted = 1'b1;
		end
	endtask

	// walk rd_sel over the three slices and the flag word
	task automatic read_slices();
		for (int s = 0; s < 4; s++) begin
			@(negedge strob_fp_);
			rd_sel = fpa_slice_e'(s);
			rd_chk = 1'b1;
		end
		@(negedge strob_fp_);
		rd_chk    = 1'b0;
		test_done = 1'b1;
		@(negedge strob_fp_);
		test_done = 1'b0;
	endtask

	initial begin
		int              fd;
		int              n;
		int              rnd;
		int              gap;
		int              wt;
		int              chk;
		logic [2:0]      c_code;
		logic [15:0]     w_val;
		logic [15:0]     e_hi;
		logic [15:0]     e_mid;
		logic [15:0]     e_lo;
		logic [15:0]     e_flg;
		logic [31:0]     r;
		string           line;
		seed      = 86162;
		strob_fp_ = 1'b0;
		_0_t_     = 1'b0;
		cmd_stb   = 1'b0;
		cmd       = cmd_nop;
		w         = '0;
		rd_sel    = slice_hi;
		rd_chk    = 1'b0;
		use_exp   = 1'b0;
		exp_words = '0;
		test_done = 1'b0;
		aborted   = 1'b0;
		repeat (16) @(negedge strob_fp_);
		_0_t_ = 1'b1;
		fd = $fopen("test/fpa_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/fpa_tests.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			if ($fgets(line, fd) == 0) begin
				break;
			end
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", c_code, w_val, rnd, gap, wt,
				chk, e_hi, e_mid, e_lo, e_flg);
			if (n != 10) begin
				$display("malformed line in test file: %s", line);
				aborted = 1'b1;
				continue;
			end
			// random data above the slice selector bits
			if (rnd != 0) begin
				r = $random(seed);
				w_val = {r[15:2], w_val[1:0]};
			end
			@(negedge strob_fp_);
			cmd_stb = 1'b1;
			cmd     = fpa_cmd_e'(c_code);
			w       = w_val;
			idle_cycles(gap);
			if (wt != 0 || chk != 0) begin
				idle_cycles(1);
				wait_not_busy();
			end
			if (chk != 0 && !aborted) begin
				// two more edges for the last uop and the flag register
				idle_cycles(2);
				use_exp   = (chk == 1);
				exp_words = {e_hi, e_mid, e_lo, e_flg};
				read_slices();
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		idle_cycles(2);
		$display("%0d tests, %0d errors", tests, errors);
		if (aborted || errors != 0 || tests == 0) begin
			$display("*** FAILED ***");
		end else begin
			$display("*** PASSED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
